// File: sort_pkg.sv
// Quicksort accelerator definitions
`default_nettype none

package sort_pkg;

  localparam int DATA_W = 32;
  localparam int IDX_W  = 16;

  // Host register map
  localparam logic [1:0] REG_GO    = 2'd0;
  localparam logic [1:0] REG_BASE  = 2'd1;
  localparam logic [1:0] REG_SIZE  = 2'd2;
  localparam logic [1:0] REG_STACK = 2'd3;

  // Stack entry, a half-open range [low, high)
  typedef struct packed {
    logic [IDX_W-1:0] high;
    logic [IDX_W-1:0] low;
  } stack_range_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    stack_range_t      range;
  } stack_entry_u;

  typedef enum logic [2:0] {
    ELEM_J, ELEM_I, ELEM_PIVOT, STACK_TOP, STACK_PUSH
  } addr_sel_t;

  typedef enum logic [1:0] {
    VAL_I, VAL_J, PIVOT, ENTRY
  } wdata_sel_t;

  typedef enum logic [4:0] {
    S_IDLE, S_INIT, S_CHECK, S_RD_PIVOT, S_WT_PIVOT, S_LOOP,
    S_RD_J, S_WT_J, S_CMP, S_RD_I, S_WT_I, S_WR_I, S_WR_J,
    S_PUSH, S_POP, S_WT_POP, S_FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: sort_xcel_regs.sv
// Host register port
`timescale 1ns/100ps
`default_nettype none

module sort_xcel_regs (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      xcel_req_val_i,
  output logic                           xcel_req_rdy_o,
  input  wire logic                      xcel_req_write_i,
  input  wire logic [1:0]                xcel_req_addr_i,
  input  wire logic [sort_pkg::DATA_W-1:0] xcel_req_data_i,
  output logic                           xcel_resp_val_o,
  input  wire logic                      xcel_resp_rdy_i,
  output logic [sort_pkg::DATA_W-1:0]    xcel_resp_data_o,
  input  wire logic                      busy_i,
  output logic                           go_o,
  output logic [sort_pkg::DATA_W-1:0]    base_addr_o,
  output logic [sort_pkg::IDX_W-1:0]     size_o,
  output logic [sort_pkg::DATA_W-1:0]    stack_addr_o
);
  import sort_pkg::*;

  logic req_xfer;
  logic wr_xfer;

  // Requests wait here until the engine is idle
  assign xcel_req_rdy_o  = !busy_i && xcel_resp_rdy_i;
  assign xcel_resp_val_o = xcel_req_val_i && !busy_i;
  assign req_xfer        = xcel_req_val_i && xcel_req_rdy_o;
  assign wr_xfer         = req_xfer && xcel_req_write_i;

  // Reads only complete once idle, so they always report done
  assign xcel_resp_data_o = xcel_req_write_i ? '0 : DATA_W'(1);

  assign go_o = wr_xfer && (xcel_req_addr_i == REG_GO);

  // --------------------
  // Configuration registers
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      base_addr_o  <= '0;
      size_o       <= '0;
      stack_addr_o <= '0;
    end else if (wr_xfer) begin
      case (xcel_req_addr_i)
        REG_BASE:  base_addr_o  <= xcel_req_data_i;
        REG_SIZE:  size_o       <= xcel_req_data_i[IDX_W-1:0];
        REG_STACK: stack_addr_o <= xcel_req_data_i;
        default:   ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sort_mem_port.sv
// Memory request and response handling
`timescale 1ns/100ps
`default_nettype none

module sort_mem_port #(
  parameter int WR_CNT_W = 6
) (
  input  wire logic                        clk,
  input  wire logic                        reset,
  output logic                             mem_req_val_o,
  input  wire logic                        mem_req_rdy_i,
  output logic                             mem_req_write_o,
  output logic [sort_pkg::DATA_W-1:0]      mem_req_addr_o,
  output logic [sort_pkg::DATA_W-1:0]      mem_req_data_o,
  input  wire logic                        mem_resp_val_i,
  output logic                             mem_resp_rdy_o,
  input  wire logic                        mem_resp_write_i,
  input  wire logic [sort_pkg::DATA_W-1:0] mem_resp_data_i,
  input  wire logic                        req_i,
  input  wire logic                        req_write_i,
  input  wire sort_pkg::addr_sel_t         addr_sel_i,
  input  wire sort_pkg::wdata_sel_t        wdata_sel_i,
  output logic                             req_done_o,
  input  wire logic                        rd_wait_i,
  output logic                             rd_valid_o,
  output logic [sort_pkg::DATA_W-1:0]      rd_data_o,
  output logic                             writes_idle_o,
  input  wire logic [sort_pkg::DATA_W-1:0] base_addr_i,
  input  wire logic [sort_pkg::DATA_W-1:0] stack_addr_i,
  input  wire logic [sort_pkg::IDX_W-1:0]  idx_i_i,
  input  wire logic [sort_pkg::IDX_W-1:0]  idx_j_i,
  input  wire logic [sort_pkg::IDX_W-1:0]  high_i,
  input  wire logic [sort_pkg::IDX_W-1:0]  top_i,
  input  wire logic [sort_pkg::DATA_W-1:0] val_i_i,
  input  wire logic [sort_pkg::DATA_W-1:0] val_j_i,
  input  wire logic [sort_pkg::DATA_W-1:0] pivot_i,
  input  wire logic [sort_pkg::DATA_W-1:0] entry_i
);
  import sort_pkg::*;

  logic [DATA_W-1:0]   region;
  logic [IDX_W-1:0]    idx_sel;
  logic [WR_CNT_W-1:0] wr_cnt;
  logic                wr_inc;
  logic                wr_dec;

  // Word address is region base plus index times four
  always_comb begin
    region  = base_addr_i;
    idx_sel = idx_j_i;
    case (addr_sel_i)
      ELEM_I:     idx_sel = idx_i_i;
      ELEM_PIVOT: idx_sel = high_i - 1'b1;
      STACK_TOP: begin
        region  = stack_addr_i;
        idx_sel = top_i - 1'b1;
      end
      STACK_PUSH: begin
        region  = stack_addr_i;
        idx_sel = top_i;
      end
      default:    ;
    endcase
  end

  assign mem_req_addr_o = region + {{(DATA_W-IDX_W-2){1'b0}}, idx_sel, 2'b00};

  always_comb begin
    case (wdata_sel_i)
      VAL_I:   mem_req_data_o = val_i_i;
      PIVOT:   mem_req_data_o = pivot_i;
      ENTRY:   mem_req_data_o = entry_i;
      default: mem_req_data_o = val_j_i;
    endcase
  end

  assign mem_req_val_o   = req_i;
  assign mem_req_write_o = req_write_i;
  assign req_done_o      = req_i && mem_req_rdy_i;

  // Write acks always drain, read data only when expected
  assign mem_resp_rdy_o = mem_resp_write_i || rd_wait_i;
  assign rd_valid_o     = mem_resp_val_i && !mem_resp_write_i && rd_wait_i;
  assign rd_data_o      = mem_resp_data_i;

  // --------------------
  // Outstanding writes
  // --------------------
  assign wr_inc = req_done_o && req_write_i;
  assign wr_dec = mem_resp_val_i && mem_resp_write_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_cnt <= '0;
    end else if (wr_inc && !wr_dec) begin
      wr_cnt <= wr_cnt + 1'b1;
    end else if (wr_dec && !wr_inc) begin
      wr_cnt <= wr_cnt - 1'b1;
    end
  end

  assign writes_idle_o = (wr_cnt == '0);

endmodule

`default_nettype wire

// File: sort_partition.sv
// Partition datapath and range stack pointer
`timescale 1ns/100ps
`default_nettype none

module sort_partition (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        start_i,
  input  wire logic [sort_pkg::IDX_W-1:0]  size_i,
  input  wire logic                        pop_i,
  input  wire logic                        pivot_ld_i,
  input  wire logic                        valj_ld_i,
  input  wire logic                        vali_ld_i,
  input  wire logic                        step_i,
  input  wire logic                        swap_done_i,
  input  wire logic                        push_i,
  input  wire logic                        next_i,
  input  wire logic [sort_pkg::DATA_W-1:0] rd_data_i,
  output logic [sort_pkg::IDX_W-1:0]       idx_i_o,
  output logic [sort_pkg::IDX_W-1:0]       idx_j_o,
  output logic [sort_pkg::IDX_W-1:0]       high_o,
  output logic [sort_pkg::IDX_W-1:0]       top_o,
  output logic [sort_pkg::DATA_W-1:0]      val_i_o,
  output logic [sort_pkg::DATA_W-1:0]      val_j_o,
  output logic [sort_pkg::DATA_W-1:0]      pivot_o,
  output logic [sort_pkg::DATA_W-1:0]      entry_o,
  output logic                             lt_pivot_o,
  output logic                             j_at_end_o,
  output logic                             left_push_o,
  output logic                             right_push_o,
  output logic                             stack_empty_o
);
  import sort_pkg::*;

  logic [IDX_W-1:0] low;
  logic             left_push;
  logic             right_push;
  stack_entry_u     pop_entry;
  stack_entry_u     push_entry;

  assign pop_entry.raw = rd_data_i;

  // Pivot ends at idx_i, leaving [low, i) and [i+1, high)
  assign left_push  = {1'b0, idx_i_o} >= ({1'b0, low} + 2'd2);
  assign right_push = {1'b0, high_o} >= ({1'b0, idx_i_o} + 2'd3);

  // Left side goes first, then right
  always_comb begin
    if (left_push) begin
      push_entry.range.high = idx_i_o;
      push_entry.range.low  = low;
    end else begin
      push_entry.range.high = high_o;
      push_entry.range.low  = idx_i_o + 1'b1;
    end
  end

  // --------------------
  // Range and index registers
  // --------------------
  always_ff @(posedge clk) begin
    if (start_i) begin
      low    <= '0;
      high_o <= size_i;
    end else if (pop_i) begin
      low    <= pop_entry.range.low;
      high_o <= pop_entry.range.high;
    end else if (next_i) begin
      idx_i_o <= low;
      idx_j_o <= low;
    end else if (step_i) begin
      idx_j_o <= idx_j_o + 1'b1;
    end else if (swap_done_i) begin
      idx_i_o <= idx_i_o + 1'b1;
      idx_j_o <= idx_j_o + 1'b1;
    end else if (push_i) begin
      // Collapse the side just pushed so the other one follows
      if (left_push) low    <= idx_i_o;
      else           high_o <= idx_i_o + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pivot_ld_i) pivot_o <= rd_data_i;
    if (valj_ld_i)  val_j_o <= rd_data_i;
    if (vali_ld_i)  val_i_o <= rd_data_i;
  end

  always_ff @(posedge clk) begin
    if (reset || start_i) begin
      top_o <= '0;
    end else if (push_i) begin
      top_o <= top_o + 1'b1;
    end else if (pop_i) begin
      top_o <= top_o - 1'b1;
    end
  end

  assign entry_o       = push_entry.raw;
  assign lt_pivot_o    = val_j_o < pivot_o;
  assign j_at_end_o    = ({1'b0, idx_j_o} + 1'b1) >= {1'b0, high_o};
  assign left_push_o   = left_push;
  assign right_push_o  = right_push;
  assign stack_empty_o = (top_o == '0);

endmodule

`default_nettype wire

// File: sort_ctrl.sv
// Quicksort sequencing FSM
`timescale 1ns/100ps
`default_nettype none

module sort_ctrl (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire logic           go_i,
  output logic                busy_o,
  output logic                req_o,
  output logic                req_write_o,
  output sort_pkg::addr_sel_t  addr_sel_o,
  output sort_pkg::wdata_sel_t wdata_sel_o,
  input  wire logic           req_done_i,
  output logic                rd_wait_o,
  input  wire logic           rd_valid_i,
  input  wire logic           writes_idle_i,
  output logic                start_o,
  output logic                pop_o,
  output logic                pivot_ld_o,
  output logic                valj_ld_o,
  output logic                vali_ld_o,
  output logic                step_o,
  output logic                swap_done_o,
  output logic                push_o,
  output logic                next_o,
  input  wire logic           lt_pivot_i,
  input  wire logic           j_at_end_i,
  input  wire logic           left_push_i,
  input  wire logic           right_push_i,
  input  wire logic           stack_empty_i
);
  import sort_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (reset) state <= S_IDLE;
    else       state <= state_nxt;
  end

  assign busy_o    = (state != S_IDLE);
  assign rd_wait_o = (state == S_WT_PIVOT) || (state == S_WT_J) ||
                     (state == S_WT_I) || (state == S_WT_POP);

  always_comb begin
    state_nxt   = state;
    req_o       = 1'b0;
    req_write_o = 1'b0;
    addr_sel_o  = ELEM_J;
    wdata_sel_o = VAL_J;
    start_o     = 1'b0;
    pop_o       = 1'b0;
    pivot_ld_o  = 1'b0;
    valj_ld_o   = 1'b0;
    vali_ld_o   = 1'b0;
    step_o      = 1'b0;
    swap_done_o = 1'b0;
    push_o      = 1'b0;
    next_o      = 1'b0;

    case (state)
      S_IDLE: begin
        start_o = go_i;
        if (go_i) state_nxt = S_INIT;
      end
      S_INIT: begin
        next_o    = 1'b1;
        state_nxt = S_CHECK;
      end
      // Only the initial range can be shorter than two
      S_CHECK:    state_nxt = j_at_end_i ? S_POP : S_RD_PIVOT;

      // --------------------
      // Partition loop
      // --------------------
      S_RD_PIVOT: begin
        req_o      = 1'b1;
        addr_sel_o = ELEM_PIVOT;
        if (req_done_i) state_nxt = S_WT_PIVOT;
      end
      S_WT_PIVOT: begin
        pivot_ld_o = rd_valid_i;
        if (rd_valid_i) state_nxt = S_LOOP;
      end
      // At the pivot slot, the same read and swap does the final exchange
      S_LOOP:     state_nxt = j_at_end_i ? S_RD_I : S_RD_J;
      S_RD_J: begin
        req_o = 1'b1;
        if (req_done_i) state_nxt = S_WT_J;
      end
      S_WT_J: begin
        valj_ld_o = rd_valid_i;
        if (rd_valid_i) state_nxt = S_CMP;
      end
      S_CMP: begin
        step_o    = !lt_pivot_i;
        state_nxt = lt_pivot_i ? S_RD_I : S_LOOP;
      end
      S_RD_I: begin
        req_o      = 1'b1;
        addr_sel_o = ELEM_I;
        if (req_done_i) state_nxt = S_WT_I;
      end
      S_WT_I: begin
        vali_ld_o = rd_valid_i;
        if (rd_valid_i) state_nxt = S_WR_I;
      end
      S_WR_I: begin
        req_o       = 1'b1;
        req_write_o = 1'b1;
        addr_sel_o  = ELEM_I;
        wdata_sel_o = j_at_end_i ? PIVOT : VAL_J;
        if (req_done_i) state_nxt = S_WR_J;
      end
      S_WR_J: begin
        req_o       = 1'b1;
        req_write_o = 1'b1;
        wdata_sel_o = VAL_I;
        swap_done_o = req_done_i && !j_at_end_i;
        if (req_done_i) state_nxt = j_at_end_i ? S_PUSH : S_LOOP;
      end

      // --------------------
      // Range stack
      // --------------------
      S_PUSH: begin
        if (left_push_i || right_push_i) begin
          req_o       = 1'b1;
          req_write_o = 1'b1;
          addr_sel_o  = STACK_PUSH;
          wdata_sel_o = ENTRY;
          push_o      = req_done_i;
        end else begin
          state_nxt = S_POP;
        end
      end
      S_POP: begin
        if (stack_empty_i) begin
          state_nxt = S_FINISH;
        end else begin
          req_o      = 1'b1;
          addr_sel_o = STACK_TOP;
          if (req_done_i) state_nxt = S_WT_POP;
        end
      end
      S_WT_POP: begin
        pop_o = rd_valid_i;
        if (rd_valid_i) state_nxt = S_INIT;
      end
      S_FINISH:   if (writes_idle_i) state_nxt = S_IDLE;
      default:    state_nxt = S_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// File: sort_xcel.sv
// Quicksort accelerator top level
`timescale 1ns/100ps
`default_nettype none

module sort_xcel #(
  parameter int WR_CNT_W = 6
) (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        xcel_req_val_i,
  output logic                             xcel_req_rdy_o,
  input  wire logic                        xcel_req_write_i,
  input  wire logic [1:0]                  xcel_req_addr_i,
  input  wire logic [sort_pkg::DATA_W-1:0] xcel_req_data_i,
  output logic                             xcel_resp_val_o,
  input  wire logic                        xcel_resp_rdy_i,
  output logic [sort_pkg::DATA_W-1:0]      xcel_resp_data_o,
  output logic                             mem_req_val_o,
  input  wire logic                        mem_req_rdy_i,
  output logic                             mem_req_write_o,
  output logic [sort_pkg::DATA_W-1:0]      mem_req_addr_o,
  output logic [sort_pkg::DATA_W-1:0]      mem_req_data_o,
  input  wire logic                        mem_resp_val_i,
  output logic                             mem_resp_rdy_o,
  input  wire logic                        mem_resp_write_i,
  input  wire logic [sort_pkg::DATA_W-1:0] mem_resp_data_i
);
  import sort_pkg::*;

  logic              busy, go, req, req_write, req_done;
  logic              rd_wait, rd_valid, writes_idle;
  addr_sel_t         addr_sel;
  wdata_sel_t        wdata_sel;
  logic [DATA_W-1:0] base_addr, stack_addr, rd_data;
  logic [IDX_W-1:0]  size;

  // Datapath state towards the memory port
  logic [IDX_W-1:0]  idx_i, idx_j, high, top;
  logic [DATA_W-1:0] val_i, val_j, pivot, entry;

  // Strobes and flags between FSM and datapath
  logic start, pop, pivot_ld, valj_ld, vali_ld, step, swap_done, push, next;
  logic lt_pivot, j_at_end, left_push, right_push, stack_empty;

  sort_xcel_regs i_regs (
    .clk, .reset,
    .xcel_req_val_i, .xcel_req_rdy_o, .xcel_req_write_i, .xcel_req_addr_i,
    .xcel_req_data_i, .xcel_resp_val_o, .xcel_resp_rdy_i, .xcel_resp_data_o,
    .busy_i(busy), .go_o(go), .base_addr_o(base_addr), .size_o(size),
    .stack_addr_o(stack_addr)
  );

  sort_mem_port #(.WR_CNT_W(WR_CNT_W)) i_mem_port (
    .clk, .reset,
    .mem_req_val_o, .mem_req_rdy_i, .mem_req_write_o, .mem_req_addr_o,
    .mem_req_data_o, .mem_resp_val_i, .mem_resp_rdy_o, .mem_resp_write_i,
    .mem_resp_data_i,
    .req_i(req), .req_write_i(req_write), .addr_sel_i(addr_sel),
    .wdata_sel_i(wdata_sel), .req_done_o(req_done), .rd_wait_i(rd_wait),
    .rd_valid_o(rd_valid), .rd_data_o(rd_data), .writes_idle_o(writes_idle),
    .base_addr_i(base_addr), .stack_addr_i(stack_addr),
    .idx_i_i(idx_i), .idx_j_i(idx_j), .high_i(high), .top_i(top),
    .val_i_i(val_i), .val_j_i(val_j), .pivot_i(pivot), .entry_i(entry)
  );

  sort_partition i_partition (
    .clk, .reset, .start_i(start), .size_i(size),
    .pop_i(pop), .pivot_ld_i(pivot_ld), .valj_ld_i(valj_ld), .vali_ld_i(vali_ld),
    .step_i(step), .swap_done_i(swap_done), .push_i(push), .next_i(next),
    .rd_data_i(rd_data),
    .idx_i_o(idx_i), .idx_j_o(idx_j), .high_o(high), .top_o(top),
    .val_i_o(val_i), .val_j_o(val_j), .pivot_o(pivot), .entry_o(entry),
    .lt_pivot_o(lt_pivot), .j_at_end_o(j_at_end), .left_push_o(left_push),
    .right_push_o(right_push), .stack_empty_o(stack_empty)
  );

  sort_ctrl i_ctrl (
    .clk, .reset, .go_i(go), .busy_o(busy),
    .req_o(req), .req_write_o(req_write), .addr_sel_o(addr_sel),
    .wdata_sel_o(wdata_sel), .req_done_i(req_done), .rd_wait_o(rd_wait),
    .rd_valid_i(rd_valid), .writes_idle_i(writes_idle),
    .start_o(start), .pop_o(pop), .pivot_ld_o(pivot_ld), .valj_ld_o(valj_ld),
    .vali_ld_o(vali_ld), .step_o(step), .swap_done_o(swap_done),
    .push_o(push), .next_o(next),
    .lt_pivot_i(lt_pivot), .j_at_end_i(j_at_end), .left_push_i(left_push),
    .right_push_i(right_push), .stack_empty_i(stack_empty)
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// Behavioral word memory
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model #(
  parameter int          AW   = 10,
  parameter logic [31:0] SEED = 32'h47e73353
) (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        stall_en_i,
  input  wire logic                        req_val_i,
  output logic                             req_rdy_o = 1'b0,
  input  wire logic                        req_write_i,
  input  wire logic [sort_pkg::DATA_W-1:0] req_addr_i,
  input  wire logic [sort_pkg::DATA_W-1:0] req_data_i,
  output logic                             resp_val_o = 1'b0,
  input  wire logic                        resp_rdy_i,
  output logic                             resp_write_o = 1'b0,
  output logic [sort_pkg::DATA_W-1:0]      resp_data_o = '0,
  input  wire logic                        ld_en_i,
  input  wire logic [AW-1:0]               ld_addr_i,
  input  wire logic [sort_pkg::DATA_W-1:0] ld_data_i
);
  import sort_pkg::*;

  logic [DATA_W-1:0] mem [1 << AW];
  // Write flag sits above the data word
  logic [DATA_W:0]   resp_q [$];
  int                seed = int'(SEED);

  always @(posedge clk) begin
    if (reset) begin
      resp_q.delete();
      req_rdy_o    <= 1'b0;
      resp_val_o   <= 1'b0;
      resp_write_o <= 1'b0;
      resp_data_o  <= '0;
    end else begin
      if (resp_val_o && resp_rdy_i) begin
        void'(resp_q.pop_front());
      end
      if (req_val_i && req_rdy_o) begin
        if (req_write_i) begin
          mem[req_addr_i[AW+1:2]] <= req_data_i;
          resp_q.push_back({1'b1, {DATA_W{1'b0}}});
        end else begin
          resp_q.push_back({1'b0, mem[req_addr_i[AW+1:2]]});
        end
      end
      // Preload path from the testbench
      if (ld_en_i) begin
        mem[ld_addr_i] <= ld_data_i;
      end
      req_rdy_o    <= !stall_en_i || ($random(seed) % 3 != 0);
      resp_val_o   <= resp_q.size() != 0;
      resp_write_o <= (resp_q.size() != 0) && resp_q[0][DATA_W];
      resp_data_o  <= (resp_q.size() != 0) ? resp_q[0][DATA_W-1:0] : '0;
    end
  end

endmodule

`default_nettype wire

// File: tb_sort_xcel.sv
// Quicksort accelerator testbench
`timescale 1ns/100ps
`default_nettype none

module tb_sort_xcel;
  import sort_pkg::*;

  localparam int MEM_AW    = 10;
  localparam int MEM_WORDS = 1 << MEM_AW;
  localparam int ARR_W     = 'h200 / 4;
  localparam int STK_W     = 'h800 / 4;
  localparam int STK_WORDS = 64;
  localparam int TIMEOUT   = 100000;

  typedef logic [DATA_W-1:0] word_q_t [$];

  logic              clk              = 1'b0;
  logic              reset            = 1'b1;
  logic              xcel_req_val_i   = 1'b0;
  logic              xcel_req_rdy_o;
  logic              xcel_req_write_i = 1'b0;
  logic [1:0]        xcel_req_addr_i  = '0;
  logic [DATA_W-1:0] xcel_req_data_i  = '0;
  logic              xcel_resp_val_o;
  logic              xcel_resp_rdy_i  = 1'b1;
  logic [DATA_W-1:0] xcel_resp_data_o;
  logic              mem_req_val_o, mem_req_rdy_i, mem_req_write_o;
  logic [DATA_W-1:0] mem_req_addr_o, mem_req_data_o, mem_resp_data_i;
  logic              mem_resp_val_i, mem_resp_rdy_o, mem_resp_write_i;
  logic              stall_en   = 1'b0;
  logic              ld_en      = 1'b0;
  logic [MEM_AW-1:0] ld_addr    = '0;
  logic [DATA_W-1:0] ld_data    = '0;
  int                seed       = 32'h47e73353;
  int                resp_count = 0;
  int                req_count  = 0;

  sort_xcel #(.WR_CNT_W(6)) i_sort_xcel (.*);

  tb_mem_model #(.AW(MEM_AW), .SEED(32'h47e73353)) i_mem (
    .clk, .reset, .stall_en_i(stall_en),
    .req_val_i(mem_req_val_o), .req_rdy_o(mem_req_rdy_i), .req_write_i(mem_req_write_o),
    .req_addr_i(mem_req_addr_o), .req_data_i(mem_req_data_o),
    .resp_val_o(mem_resp_val_i), .resp_rdy_i(mem_resp_rdy_o),
    .resp_write_o(mem_resp_write_i), .resp_data_o(mem_resp_data_i),
    .ld_en_i(ld_en), .ld_addr_i(ld_addr), .ld_data_i(ld_data)
  );

  always #20 clk = ~clk;

  // Host back-pressure on responses
  always @(posedge clk) begin
    xcel_resp_rdy_i <= !stall_en || ($random(seed) % 4 != 0);
  end

  always @(negedge clk) begin
    if (!reset && xcel_resp_val_o && xcel_resp_rdy_i) begin
      resp_count <= resp_count + 1;
    end
  end

  // --------------------
  // Reference and checks
  // --------------------
  function automatic word_q_t sorted_copy(input word_q_t vals);
    word_q_t           res;
    logic [DATA_W-1:0] key;
    int                p;
    res = vals;
    for (int m = 1; m < res.size(); m++) begin
      key = res[m];
      p = m - 1;
      while (p >= 0 && res[p] > key) begin
        res[p+1] = res[p];
        p--;
      end
      res[p+1] = key;
    end
    return res;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input int k);
    return ((32'(k) << 2) * 32'h9e3779b1) ^ 32'h5ac30f96;
  endfunction

  function automatic word_q_t random_words(input int n, input logic [DATA_W-1:0] mask);
    word_q_t res;
    for (int k = 0; k < n; k++) begin
      res.push_back(DATA_W'($random(seed)) & mask);
    end
    return res;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: expected response %h, actual %h", name, exp, act));
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic host_access(input string name, input logic wr, input logic [1:0] addr,
                             input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] rdata);
    int waited;
    int resp_before;
    waited = 0;
    resp_before = resp_count;
    @(posedge clk);
    xcel_req_val_i   <= 1'b1;
    xcel_req_write_i <= wr;
    xcel_req_addr_i  <= addr;
    xcel_req_data_i  <= data;
    @(negedge clk);
    while (!(xcel_req_val_i && xcel_req_rdy_o)) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_run($sformatf("%s: the host request was not accepted in time", name));
      end
      @(negedge clk);
    end
    rdata = xcel_resp_data_o;
    @(posedge clk);
    xcel_req_val_i <= 1'b0;
    req_count++;
    @(negedge clk);
    if (resp_count != resp_before + 1) begin
      stop_run($sformatf("%s: host request did not get exactly one response", name));
    end
  endtask

  task automatic run_sort(input string name, input word_q_t vals);
    word_q_t           expect_q;
    logic [DATA_W-1:0] rdata;
    int                n;
    n = vals.size();
    expect_q = sorted_copy(vals);
    for (int k = 0; k < MEM_WORDS; k++) begin
      @(posedge clk);
      ld_en   <= 1'b1;
      ld_addr <= MEM_AW'(k);
      ld_data <= (k >= ARR_W && k < ARR_W + n) ? vals[k - ARR_W] : fill_word(k);
    end
    @(posedge clk);
    ld_en <= 1'b0;

    host_access(name, 1'b1, REG_BASE, DATA_W'(ARR_W * 4), rdata);
    check_resp({name, " base write"}, '0, rdata);
    host_access(name, 1'b1, REG_SIZE, DATA_W'(n), rdata);
    check_resp({name, " size write"}, '0, rdata);
    host_access(name, 1'b1, REG_STACK, DATA_W'(STK_W * 4), rdata);
    check_resp({name, " stack write"}, '0, rdata);
    host_access(name, 1'b1, REG_GO, '0, rdata);
    check_resp({name, " go write"}, '0, rdata);
    host_access(name, 1'b0, REG_GO, '0, rdata);
    check_resp({name, " done read"}, DATA_W'(1), rdata);

    // Stack scratch words may change only when a partition ran
    for (int k = 0; k < MEM_WORDS; k++) begin
      if (k >= ARR_W && k < ARR_W + n) begin
        check_word($sformatf("%s element %0d", name, k - ARR_W), expect_q[k - ARR_W],
                   i_mem.mem[k]);
      end else if (!(n >= 2 && k >= STK_W && k < STK_W + STK_WORDS)) begin
        check_word($sformatf("%s word 0x%0h", name, 4 * k), fill_word(k), i_mem.mem[k]);
      end
    end
  endtask

  initial begin
    word_q_t reversed;
    for (int k = 0; k < 16; k++) begin
      reversed.push_back(DATA_W'(1000 - 10 * k));
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    run_sort("random_16", random_words(16, '1));
    run_sort("duplicates", random_words(16, 32'h3));
    run_sort("reversed", reversed);
    run_sort("size_0", random_words(0, '1));
    run_sort("size_1", random_words(1, '1));

    @(posedge clk);
    stall_en <= 1'b1;
    run_sort("stall_random", random_words(16, '1));
    run_sort("stall_duplicates", random_words(16, 32'h7));
    run_sort("stall_reversed", reversed);

    if (resp_count == req_count) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_run($sformatf("Host saw %0d responses for %0d requests", resp_count, req_count));
    end
  end

endmodule

`default_nettype wire

// File: tb.f
sort_pkg.sv
sort_xcel_regs.sv
sort_mem_port.sv
sort_partition.sv
sort_ctrl.sv
sort_xcel.sv
tb_mem_model.sv
tb_sort_xcel.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run the testbench, then judge the log
rm -rf obj_dir sim.log
{ verilator --binary --timing --top-module tb_sort_xcel -f tb.f -o tb_sort_xcel &&
  ./obj_dir/tb_sort_xcel; } > sim.log 2>&1 ||
  echo "Build or simulation returned a failing status" >> sim.log
cat sim.log
grep -q -F '*** TEST FAILED ***' sim.log && exit 1
grep -q -F '*** TEST PASSED ***' sim.log || exit 1
exit 0
